// ==== hw/vscale_pkg.sv ====
package vscale_pkg;

	////////////////////
	// Widths

	localparam int DIM_W = 12;
	// Top bit of an aspect value flags a direct size
	localparam int AR_W = 13;
	localparam int IO_W = 16;
	localparam int CMD_W = 8;
	localparam int WORD_CNT_W = 8;

	////////////////////
	// Host command codes

	localparam logic [CMD_W-1:0] CMD_TIMING = 8'h20;
	localparam logic [CMD_W-1:0] CMD_VSET = 8'h27;
	localparam logic [CMD_W-1:0] CMD_HSET = 8'h37;
	localparam logic [CMD_W-1:0] CMD_AR_PRESET = 8'h3A;

	// Free-scale flag inside the HSET word
	localparam int FREESCALE_BIT = 15;

	////////////////////
	// Reset defaults, 1080p frame

	localparam logic [DIM_W-1:0] WIDTH_RST = 12'd1920;
	localparam logic [DIM_W-1:0] HEIGHT_RST = 12'd1080;

	////////////////////
	// Divider

	localparam int MULDIV_STEPS = 24;
	localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS + 1);

	////////////////////
	// Host word, read as command or as data

	typedef union packed {
		struct packed {
			logic [IO_W-CMD_W-1:0] rsvd;
			logic [CMD_W-1:0]      code;
		} cmd;
		logic [IO_W-1:0] data;
	} io_word_u;

endpackage

// ==== hw/host_cmd_decoder.sv ====
`timescale 1ns/1ps

module host_cmd_decoder import vscale_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_sel,
	input  logic              i_io_clk,
	input  logic [IO_W-1:0]   i_io_din,
	output logic [DIM_W-1:0]  o_width,
	output logic [DIM_W-1:0]  o_height,
	output logic [DIM_W-1:0]  o_vset,
	output logic [DIM_W-1:0]  o_hset,
	output logic              o_freescale,
	output logic [AR_W-1:0]   o_arc1x,
	output logic [AR_W-1:0]   o_arc1y,
	output logic [AR_W-1:0]   o_arc2x,
	output logic [AR_W-1:0]   o_arc2y
);

	logic                  io_clk_s;
	logic                  io_clk_d;
	logic                  io_strobe;
	logic                  has_cmd;
	logic [CMD_W-1:0]      cmd;
	logic [WORD_CNT_W-1:0] cnt;
	io_word_u              word;

	assign word = i_io_din;

	// Rising edge of the host I/O clock
	assign io_strobe = io_clk_s & ~io_clk_d;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_s <= 1'b0;
			io_clk_d <= 1'b0;
		end else begin
			io_clk_s <= i_io_clk;
			io_clk_d <= io_clk_s;
		end
	end

	////////////////////
	// Command and data words

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd <= '0;
			cnt <= '0;
			o_width <= WIDTH_RST;
			o_height <= HEIGHT_RST;
			o_vset <= '0;
			o_hset <= '0;
			o_freescale <= 1'b0;
			o_arc1x <= '0;
			o_arc1y <= '0;
			o_arc2x <= '0;
			o_arc2y <= '0;
		end else if (!i_io_sel) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd <= word.cmd.code;
				cnt <= '0;
			end else begin
				// Counter sticks at the top so late words never alias word 0
				if (~&cnt)
					cnt <= cnt + WORD_CNT_W'(1);
				case (cmd)
					CMD_TIMING: begin
						// Porches and sync words are skipped
						if (cnt == WORD_CNT_W'(0))
							o_width <= word.data[DIM_W-1:0];
						if (cnt == WORD_CNT_W'(4))
							o_height <= word.data[DIM_W-1:0];
					end
					CMD_VSET: begin
						o_vset <= word.data[DIM_W-1:0];
					end
					CMD_HSET: begin
						o_freescale <= word.data[FREESCALE_BIT];
						o_hset <= word.data[DIM_W-1:0];
					end
					CMD_AR_PRESET: begin
						case (cnt)
							WORD_CNT_W'(0): o_arc1x <= word.data[AR_W-1:0];
							WORD_CNT_W'(1): o_arc1y <= word.data[AR_W-1:0];
							WORD_CNT_W'(2): o_arc2x <= word.data[AR_W-1:0];
							WORD_CNT_W'(3): o_arc2y <= word.data[AR_W-1:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/geometry_prep.sv ====
`timescale 1ns/1ps

module geometry_prep import vscale_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic [DIM_W-1:0]  i_width,
	input  logic [DIM_W-1:0]  i_height,
	input  logic [DIM_W-1:0]  i_vset,
	input  logic [DIM_W-1:0]  i_hset,
	input  logic [AR_W-1:0]   i_ar_x,
	input  logic [AR_W-1:0]   i_ar_y,
	input  logic [AR_W-1:0]   i_arc1x,
	input  logic [AR_W-1:0]   i_arc1y,
	input  logic [AR_W-1:0]   i_arc2x,
	input  logic [AR_W-1:0]   i_arc2y,
	output logic [DIM_W-1:0]  o_lim_w,
	output logic [DIM_W-1:0]  o_lim_h,
	output logic [DIM_W-1:0]  o_asp_x,
	output logic [DIM_W-1:0]  o_asp_y,
	output logic              o_asp_size
);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_lim_w <= '0;
			o_lim_h <= '0;
			o_asp_x <= '0;
			o_asp_y <= '0;
			o_asp_size <= 1'b0;
		end else begin
			// Zero limit means no limit
			o_lim_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			o_lim_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

			if (i_ar_y != '0) begin
				o_asp_x <= i_ar_x[DIM_W-1:0];
				o_asp_y <= i_ar_y[DIM_W-1:0];
				o_asp_size <= i_ar_x[AR_W-1] | i_ar_y[AR_W-1];
			end else if (i_ar_x == AR_W'(1)) begin
				o_asp_x <= i_arc1x[DIM_W-1:0];
				o_asp_y <= i_arc1y[DIM_W-1:0];
				o_asp_size <= i_arc1x[AR_W-1] | i_arc1y[AR_W-1];
			end else if (i_ar_x == AR_W'(2)) begin
				o_asp_x <= i_arc2x[DIM_W-1:0];
				o_asp_y <= i_arc2y[DIM_W-1:0];
				o_asp_size <= i_arc2x[AR_W-1] | i_arc2y[AR_W-1];
			end else begin
				o_asp_x <= '0;
				o_asp_y <= '0;
				o_asp_size <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/ar_muldiv.sv ====
`timescale 1ns/1ps

module ar_muldiv import vscale_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_start,
	input  logic [DIM_W-1:0]  i_mul1,
	input  logic [DIM_W-1:0]  i_mul2,
	input  logic [DIM_W-1:0]  i_div,
	output logic              o_busy,
	output logic [DIM_W-1:0]  o_result
);

	logic [MULDIV_CNT_W-1:0] steps;
	logic [2*DIM_W-1:0]      quo;
	logic [DIM_W-1:0]        rem;
	logic [DIM_W-1:0]        div_q;
	logic [DIM_W:0]          rem_sh;
	logic [DIM_W:0]          rem_sub;

	// Next dividend bit shifts into the partial remainder
	assign rem_sh = {rem, quo[2*DIM_W-1]};
	assign rem_sub = rem_sh - {1'b0, div_q};
	assign o_result = quo[DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			steps <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			steps <= MULDIV_CNT_W'(MULDIV_STEPS);
		end else if (o_busy) begin
			steps <= steps - MULDIV_CNT_W'(1);
			if (steps == MULDIV_CNT_W'(1))
				o_busy <= 1'b0;
		end
	end

	////////////////////
	// Restoring division, one quotient bit per cycle

	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo <= i_mul1 * i_mul2;
			rem <= '0;
			div_q <= i_div;
		end else if (o_busy) begin
			if (rem_sh >= {1'b0, div_q}) begin
				rem <= rem_sub[DIM_W-1:0];
				quo <= {quo[2*DIM_W-2:0], 1'b1};
			end else begin
				rem <= rem_sh[DIM_W-1:0];
				quo <= {quo[2*DIM_W-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== hw/window_calc.sv ====
`timescale 1ns/1ps

module window_calc import vscale_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic [DIM_W-1:0]  i_width,
	input  logic [DIM_W-1:0]  i_height,
	input  logic [DIM_W-1:0]  i_lim_w,
	input  logic [DIM_W-1:0]  i_lim_h,
	input  logic [DIM_W-1:0]  i_asp_x,
	input  logic [DIM_W-1:0]  i_asp_y,
	input  logic              i_asp_size,
	input  logic              i_freescale,
	output logic [DIM_W-1:0]  o_hmin,
	output logic [DIM_W-1:0]  o_hmax,
	output logic [DIM_W-1:0]  o_vmin,
	output logic [DIM_W-1:0]  o_vmax
);

	logic [2:0]       state;
	logic             use_lim;
	logic             md_start;
	logic             md_busy;
	logic [DIM_W-1:0] md_mul1;
	logic [DIM_W-1:0] md_mul2;
	logic [DIM_W-1:0] md_div;
	logic [DIM_W-1:0] md_res;
	logic [DIM_W-1:0] wcalc;
	logic [DIM_W-1:0] hcalc;
	logic [DIM_W-1:0] videow;
	logic [DIM_W-1:0] videoh;
	logic [DIM_W-1:0] h_off;
	logic [DIM_W-1:0] v_off;

	ar_muldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// No usable ratio, fill the limited size
	assign use_lim = i_freescale || i_asp_x == '0 || i_asp_y == '0;

	assign h_off = (i_width - videow) >> 1;
	assign v_off = (i_height - videoh) >> 1;

	////////////////////
	// State loop and edges

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= '0;
			md_start <= 1'b0;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			md_start <= 1'b0;
			state <= state + 3'd1;
			case (state)
				3'd0: begin
					if (use_lim || i_asp_size)
						state <= 3'd6;
				end
				3'd1: md_start <= 1'b1;
				3'd2: if (md_start | md_busy) state <= 3'd2;
				3'd3: md_start <= 1'b1;
				3'd4: if (md_start | md_busy) state <= 3'd4;
				3'd7: begin
					o_hmin <= h_off;
					o_hmax <= h_off + videow - DIM_W'(1);
					o_vmin <= v_off;
					o_vmax <= v_off + videoh - DIM_W'(1);
				end
				default: ;
			endcase
		end
	end

	////////////////////
	// Window size

	always_ff @(posedge clk_sys) begin
		case (state)
			3'd0: begin
				if (use_lim) begin
					wcalc <= i_lim_w;
					hcalc <= i_lim_h;
				end else if (i_asp_size) begin
					wcalc <= i_asp_x;
					hcalc <= i_asp_y;
				end
			end
			// Width from height and ratio
			3'd1: begin
				md_mul1 <= i_lim_h;
				md_mul2 <= i_asp_x;
				md_div <= i_asp_y;
			end
			3'd2: wcalc <= md_res;
			3'd3: begin
				md_mul1 <= i_lim_w;
				md_mul2 <= i_asp_y;
				md_div <= i_asp_x;
			end
			3'd4: hcalc <= md_res;
			3'd6: begin
				videow <= (wcalc > i_lim_w) ? i_lim_w : wcalc;
				videoh <= (hcalc > i_lim_h) ? i_lim_h : hcalc;
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/vscale_top.sv ====
`timescale 1ns/1ps

module vscale_top import vscale_pkg::*; (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_sel,
	input  logic              i_io_clk,
	input  logic [IO_W-1:0]   i_io_din,
	input  logic [AR_W-1:0]   i_ar_x,
	input  logic [AR_W-1:0]   i_ar_y,
	output logic [DIM_W-1:0]  o_hmin,
	output logic [DIM_W-1:0]  o_hmax,
	output logic [DIM_W-1:0]  o_vmin,
	output logic [DIM_W-1:0]  o_vmax
);

	logic [DIM_W-1:0] width;
	logic [DIM_W-1:0] height;
	logic [DIM_W-1:0] vset;
	logic [DIM_W-1:0] hset;
	logic             freescale;
	logic [AR_W-1:0]  arc1x;
	logic [AR_W-1:0]  arc1y;
	logic [AR_W-1:0]  arc2x;
	logic [AR_W-1:0]  arc2y;
	logic [DIM_W-1:0] lim_w;
	logic [DIM_W-1:0] lim_h;
	logic [DIM_W-1:0] asp_x;
	logic [DIM_W-1:0] asp_y;
	logic             asp_size;

	host_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_hset      (hset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y)
	);

	geometry_prep u_geometry (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_width    (width),
		.i_height   (height),
		.i_vset     (vset),
		.i_hset     (hset),
		.i_ar_x     (i_ar_x),
		.i_ar_y     (i_ar_y),
		.i_arc1x    (arc1x),
		.i_arc1y    (arc1y),
		.i_arc2x    (arc2x),
		.i_arc2y    (arc2y),
		.o_lim_w    (lim_w),
		.o_lim_h    (lim_h),
		.o_asp_x    (asp_x),
		.o_asp_y    (asp_y),
		.o_asp_size (asp_size)
	);

	window_calc u_window (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_lim_w     (lim_w),
		.i_lim_h     (lim_h),
		.i_asp_x     (asp_x),
		.i_asp_y     (asp_y),
		.i_asp_size  (asp_size),
		.i_freescale (freescale),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

endmodule

// ==== include/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Each I/O clock level lasts this many clk_sys cycles
localparam int IO_HOLD = 3;

task automatic hold_cycles(input int n);
	repeat (n) @(negedge clk_sys);
endtask

////////////////////
// Host port writes

// Command word first, then n_data words taken from wr_buf
task automatic host_write(input logic [CMD_W-1:0] code, input int n_data);
	io_word_u w;
	int i;
	w.data = '0;
	w.cmd.code = code;
	io_sel = 1'b1;
	for (i = 0; i <= n_data; i++) begin
		io_clk = 1'b0;
		if (i == 0)
			io_din = w.data;
		else
			io_din = wr_buf[i-1];
		hold_cycles(IO_HOLD);
		io_clk = 1'b1;
		hold_cycles(IO_HOLD);
	end
	io_clk = 1'b0;
	hold_cycles(IO_HOLD);
	io_sel = 1'b0;
	hold_cycles(IO_HOLD);
endtask

////////////////////
// Expected window, packed as hmin, hmax, vmin, vmax

function automatic logic [4*DIM_W-1:0] model_window();
	logic [DIM_W-1:0]   lim_w;
	logic [DIM_W-1:0]   lim_h;
	logic [DIM_W-1:0]   ax;
	logic [DIM_W-1:0]   ay;
	logic               size;
	logic [DIM_W-1:0]   wc;
	logic [DIM_W-1:0]   hc;
	logic [DIM_W-1:0]   vw;
	logic [DIM_W-1:0]   vh;
	logic [DIM_W-1:0]   ho;
	logic [DIM_W-1:0]   vo;
	logic [2*DIM_W-1:0] prod;
	logic [2*DIM_W-1:0] quot;

	lim_w = (m_hset != '0 && m_hset < m_width) ? m_hset : m_width;
	lim_h = (m_vset != '0 && m_vset < m_height) ? m_vset : m_height;

	ax = '0;
	ay = '0;
	size = 1'b0;
	if (ar_y != '0) begin
		ax = ar_x[DIM_W-1:0];
		ay = ar_y[DIM_W-1:0];
		size = ar_x[AR_W-1] | ar_y[AR_W-1];
	end else if (ar_x == AR_W'(1)) begin
		ax = m_arc1x[DIM_W-1:0];
		ay = m_arc1y[DIM_W-1:0];
		size = m_arc1x[AR_W-1] | m_arc1y[AR_W-1];
	end else if (ar_x == AR_W'(2)) begin
		ax = m_arc2x[DIM_W-1:0];
		ay = m_arc2y[DIM_W-1:0];
		size = m_arc2x[AR_W-1] | m_arc2y[AR_W-1];
	end

	if (m_freescale || ax == '0 || ay == '0) begin
		wc = lim_w;
		hc = lim_h;
	end else if (size) begin
		wc = ax;
		hc = ay;
	end else begin
		// Quotients keep only their low 12 bits
		prod = {{DIM_W{1'b0}}, lim_h} * {{DIM_W{1'b0}}, ax};
		quot = prod / {{DIM_W{1'b0}}, ay};
		wc = quot[DIM_W-1:0];
		prod = {{DIM_W{1'b0}}, lim_w} * {{DIM_W{1'b0}}, ay};
		quot = prod / {{DIM_W{1'b0}}, ax};
		hc = quot[DIM_W-1:0];
	end

	vw = (wc > lim_w) ? lim_w : wc;
	vh = (hc > lim_h) ? lim_h : hc;
	ho = (m_width - vw) >> 1;
	vo = (m_height - vh) >> 1;
	return {ho, ho + vw - DIM_W'(1), vo, vo + vh - DIM_W'(1)};
endfunction

`endif

// ==== test/tb_vscale.sv ====
`timescale 1ns/1ps

module tb_vscale import vscale_pkg::*; ();

	localparam int N_SCEN = 40;
	localparam int SCEN_CYC = 400;
	localparam int TIMEOUT_CYC = N_SCEN * SCEN_CYC;
	localparam int SETTLE_CYC = 200;

	logic             clk_sys;
	logic             resetd;
	logic             io_sel;
	logic             io_clk;
	logic [IO_W-1:0]  io_din;
	logic [AR_W-1:0]  ar_x;
	logic [AR_W-1:0]  ar_y;
	logic [DIM_W-1:0] hmin;
	logic [DIM_W-1:0] hmax;
	logic [DIM_W-1:0] vmin;
	logic [DIM_W-1:0] vmax;

	// Testbench copy of the command registers
	logic [DIM_W-1:0] m_width;
	logic [DIM_W-1:0] m_height;
	logic [DIM_W-1:0] m_vset;
	logic [DIM_W-1:0] m_hset;
	logic             m_freescale;
	logic [AR_W-1:0]  m_arc1x;
	logic [AR_W-1:0]  m_arc1y;
	logic [AR_W-1:0]  m_arc2x;
	logic [AR_W-1:0]  m_arc2y;

	logic [IO_W-1:0]  wr_buf [0:7];
	integer           seed;
	int               cycles = 0;
	int               scen = 0;
	int               checks = 0;
	int               errors = 0;

	`include "tb_model.svh"

	vscale_top dut0 (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_sel (io_sel),
		.i_io_clk (io_clk),
		.i_io_din (io_din),
		.i_ar_x   (ar_x),
		.i_ar_y   (ar_y),
		.o_hmin   (hmin),
		.o_hmax   (hmax),
		.o_vmin   (vmin),
		.o_vmax   (vmax)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYC);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [DIM_W-1:0] rand_nonzero();
		logic [31:0] r;
		r = next_rand();
		if (r[DIM_W-1:0] == '0)
			return DIM_W'(1);
		return r[DIM_W-1:0];
	endfunction

	task automatic check_value(input string name, input logic [DIM_W-1:0] got,
			input logic [DIM_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = %h, expected %h (scenario %0d)", name, got, exp, scen);
		end
	endtask

	task automatic settle_and_check();
		logic [4*DIM_W-1:0] exp;
		hold_cycles(SETTLE_CYC);
		scen++;
		exp = model_window();
		check_value("o_hmin", hmin, exp[4*DIM_W-1:3*DIM_W]);
		check_value("o_hmax", hmax, exp[3*DIM_W-1:2*DIM_W]);
		check_value("o_vmin", vmin, exp[2*DIM_W-1:DIM_W]);
		check_value("o_vmax", vmax, exp[DIM_W-1:0]);
	endtask

	// Toggles the I/O clock with select low
	task automatic send_unselected(input int n);
		int i;
		logic [31:0] r;
		for (i = 0; i < n; i++) begin
			r = next_rand();
			io_din = r[2*IO_W-1:IO_W];
			io_clk = 1'b1;
			hold_cycles(IO_HOLD);
			io_clk = 1'b0;
			hold_cycles(IO_HOLD);
		end
	endtask

	initial begin
		int i;
		int k;
		logic [31:0] r;

		clk_sys = 1'b0;
		resetd = 1'b1;
		io_sel = 1'b0;
		io_clk = 1'b0;
		io_din = '0;
		ar_x = '0;
		ar_y = '0;
		seed = 32'hda6484e2;
		m_width = WIDTH_RST;
		m_height = HEIGHT_RST;
		m_vset = '0;
		m_hset = '0;
		m_freescale = 1'b0;
		m_arc1x = '0;
		m_arc1y = '0;
		m_arc2x = '0;
		m_arc2y = '0;
		repeat (2) @(negedge clk_sys);
		resetd = 1'b0;

		// Full 1080p frame
		settle_and_check();

		////////////////////
		// Timing, size limits, core ratio

		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 6; k++) begin
				r = next_rand();
				wr_buf[k] = r[IO_W-1:0];
			end
			m_width = wr_buf[0][DIM_W-1:0];
			m_height = wr_buf[4][DIM_W-1:0];
			host_write(CMD_TIMING, 6);
			settle_and_check();
		end

		for (i = 0; i < 8; i++) begin
			// A usable ratio, so only free-scale gives the limited size
			ar_x = {1'b0, rand_nonzero()};
			ar_y = {1'b0, rand_nonzero()};
			r = next_rand();
			wr_buf[0] = r[IO_W-1:0];
			m_vset = wr_buf[0][DIM_W-1:0];
			host_write(CMD_VSET, 1);
			wr_buf[0] = r[2*IO_W-1:IO_W];
			wr_buf[0][FREESCALE_BIT] = 1'b1;
			m_hset = wr_buf[0][DIM_W-1:0];
			m_freescale = wr_buf[0][FREESCALE_BIT];
			host_write(CMD_HSET, 1);
			settle_and_check();
		end

		for (i = 0; i < 8; i++) begin
			r = next_rand();
			wr_buf[0] = {4'h0, r[DIM_W-1:0]};
			m_hset = r[DIM_W-1:0];
			m_freescale = 1'b0;
			host_write(CMD_HSET, 1);
			ar_x = {1'b0, rand_nonzero()};
			ar_y = {1'b0, rand_nonzero()};
			settle_and_check();
		end

		////////////////////
		// Presets and direct sizes

		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 4; k++) begin
				r = next_rand();
				wr_buf[k] = r[IO_W-1:0];
			end
			m_arc1x = wr_buf[0][AR_W-1:0];
			m_arc1y = wr_buf[1][AR_W-1:0];
			m_arc2x = wr_buf[2][AR_W-1:0];
			m_arc2y = wr_buf[3][AR_W-1:0];
			host_write(CMD_AR_PRESET, 4);
			r = next_rand();
			case (r[1:0])
				2'd0: begin
					ar_x = {1'b1, r[13:2]};
					ar_y = {r[14], rand_nonzero()};
				end
				2'd1: begin
					ar_x = AR_W'(1);
					ar_y = '0;
				end
				2'd2: begin
					ar_x = AR_W'(2);
					ar_y = '0;
				end
				default: begin
					ar_x = r[14:2];
					ar_y = '0;
				end
			endcase
			settle_and_check();
		end

		////////////////////
		// Select handling

		for (i = 0; i < 4; i++) begin
			send_unselected(4);
			// Cut off before the height word
			r = next_rand();
			wr_buf[0] = r[IO_W-1:0];
			wr_buf[1] = r[2*IO_W-1:IO_W];
			m_width = wr_buf[0][DIM_W-1:0];
			host_write(CMD_TIMING, 2);
			r = next_rand();
			wr_buf[0] = r[IO_W-1:0];
			m_vset = wr_buf[0][DIM_W-1:0];
			host_write(CMD_VSET, 1);
			settle_and_check();
		end

		$display("Scenarios: %0d, checks: %0d, errors: %0d", scen, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
hw/vscale_pkg.sv
hw/host_cmd_decoder.sv
hw/geometry_prep.sv
hw/ar_muldiv.sv
hw/window_calc.sv
hw/vscale_top.sv
test/tb_vscale.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_vscale -Mdir obj_dir -o tb_vscale
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_vscale > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

exit 0
